// File: design/cmac_stats_pkg.sv
/*
 * Shared widths, per-cycle increment types and enums for the 100G MAC
 * link controller and its statistics counters.
 */
`default_nettype none

package cmac_stats_pkg;

    localparam int COUNT_W   = 32;   // accumulators and readout data
    localparam int ERR_W     = 16;   // error event counters
    localparam int NUM_STATS = 11;

    // per-cycle increments as delivered by the MAC core
    typedef logic [2:0]  rx_pkt_inc_t;
    typedef logic [6:0]  rx_byte_inc_t;
    typedef logic [5:0]  tx_byte_inc_t;
    typedef logic [13:0] good_byte_inc_t;   // same width on rx and tx
    typedef logic [2:0]  err_field_t;

    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [ERR_W-1:0]   err_count_t;

    // counter selector, also the index into the counter array
    typedef enum logic [3:0] {
        SEL_RX_GOOD_PKTS   = 4'd0,
        SEL_RX_TOTAL_PKTS  = 4'd1,
        SEL_RX_GOOD_BYTES  = 4'd2,
        SEL_RX_TOTAL_BYTES = 4'd3,
        SEL_TX_GOOD_PKTS   = 4'd4,
        SEL_TX_TOTAL_PKTS  = 4'd5,
        SEL_TX_GOOD_BYTES  = 4'd6,
        SEL_TX_TOTAL_BYTES = 4'd7,
        SEL_ALIGN_ERR      = 4'd8,
        SEL_CODE_ERR       = 4'd9,
        SEL_FCS_ERR        = 4'd10
    } stat_sel_t;

    typedef enum logic [1:0] {
        LINK_IDLE       = 2'd0,
        LINK_LOCKED     = 2'd1,
        LINK_WAIT_ALIGN = 2'd2,
        LINK_UP         = 2'd3
    } link_state_t;

endpackage

`default_nettype wire

// File: design/stat_sample_if.sv
/*
 * One clock cycle of MAC statistic increments and error fields.
 * No handshake, every cycle is a sample.
 */
`timescale 1ns/1ps
`default_nettype none

interface stat_sample_if import cmac_stats_pkg::*; ();

    logic           rx_good_packets;
    rx_pkt_inc_t    rx_total_packets;
    good_byte_inc_t rx_good_bytes;
    rx_byte_inc_t   rx_total_bytes;
    logic           tx_good_packets;
    logic           tx_total_packets;
    good_byte_inc_t tx_good_bytes;
    tx_byte_inc_t   tx_total_bytes;
    logic           rx_aligned_err;
    err_field_t     rx_bad_code;
    err_field_t     rx_bad_fcs;

    modport source (
        output rx_good_packets, rx_total_packets, rx_good_bytes, rx_total_bytes,
        output tx_good_packets, tx_total_packets, tx_good_bytes, tx_total_bytes,
        output rx_aligned_err, rx_bad_code, rx_bad_fcs
    );

    modport sink (
        input rx_good_packets, rx_total_packets, rx_good_bytes, rx_total_bytes,
        input tx_good_packets, tx_total_packets, tx_good_bytes, tx_total_bytes,
        input rx_aligned_err, rx_bad_code, rx_bad_fcs
    );

endinterface

`default_nettype wire

// File: design/link_bringup_fsm.sv
/*
 * Link bring-up FSM. Enables the receiver and sends LFI/RFI after reset,
 * enables the transmitter once alignment is seen, restarts on loss.
 */
`timescale 1ns/1ps
`default_nettype none

module link_bringup_fsm import cmac_stats_pkg::*; (
    input  logic cmac_drp,
    input  logic usr_rx_reset_w,
    input  logic stat_rx_aligned,
    output logic ctl_rx_enable,
    output logic ctl_tx_enable,
    output logic ctl_tx_send_lfi,
    output logic ctl_tx_send_rfi,
    output logic link_up
);

    link_state_t state;
    logic        reset_done;
    logic        aligned_q;   // alignment from the core, one stage

    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            state           <= LINK_IDLE;
            reset_done      <= 1'b0;
            aligned_q       <= 1'b0;
            ctl_rx_enable   <= 1'b0;
            ctl_tx_enable   <= 1'b0;
            ctl_tx_send_lfi <= 1'b0;
            ctl_tx_send_rfi <= 1'b0;
        end else begin
            reset_done <= 1'b1;
            aligned_q  <= stat_rx_aligned;
            case (state)
                LINK_IDLE: begin
                    ctl_rx_enable   <= 1'b0;   // everything off, then retry
                    ctl_tx_enable   <= 1'b0;
                    ctl_tx_send_lfi <= 1'b0;
                    ctl_tx_send_rfi <= 1'b0;
                    if (reset_done) begin
                        state <= LINK_LOCKED;
                    end
                end
                LINK_LOCKED: begin
                    ctl_rx_enable   <= 1'b1;
                    ctl_tx_send_lfi <= 1'b1;   // tell the far end we are not up yet
                    ctl_tx_send_rfi <= 1'b1;
                    state           <= LINK_WAIT_ALIGN;
                end
                LINK_WAIT_ALIGN: begin
                    if (aligned_q) begin
                        state <= LINK_UP;
                    end
                end
                LINK_UP: begin
                    ctl_tx_enable   <= 1'b1;
                    ctl_tx_send_lfi <= 1'b0;
                    ctl_tx_send_rfi <= 1'b0;
                    if (!aligned_q) begin
                        state <= LINK_IDLE;
                    end
                end
                default: begin
                    state <= LINK_IDLE;
                end
            endcase
        end
    end

    assign link_up = (state == LINK_UP);

endmodule

`default_nettype wire

// File: design/stat_counter_bank.sv
/*
 * Statistics counters. Eight accumulators sum the per-cycle increments,
 * three error counters count cycles with a nonzero error field.
 * Counting only happens while the link is up.
 */
`timescale 1ns/1ps
`default_nettype none

module stat_counter_bank import cmac_stats_pkg::*; #(
    parameter int COUNT_W = $bits(count_t),
    parameter int ERR_W   = $bits(err_count_t)
) (
    input  logic               cmac_drp,
    input  logic               usr_rx_reset_w,
    input  logic               link_up,
    stat_sample_if.sink        samples,
    output logic [COUNT_W-1:0] counters [NUM_STATS]
);

    logic [COUNT_W-1:0] rx_good_pkts, rx_total_pkts, rx_good_bytes, rx_total_bytes;
    logic [COUNT_W-1:0] tx_good_pkts, tx_total_pkts, tx_good_bytes, tx_total_bytes;
    logic [ERR_W-1:0]   align_err, code_err, fcs_err;

    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            rx_good_pkts   <= '0;
            rx_total_pkts  <= '0;
            rx_good_bytes  <= '0;
            rx_total_bytes <= '0;
            tx_good_pkts   <= '0;
            tx_total_pkts  <= '0;
            tx_good_bytes  <= '0;
            tx_total_bytes <= '0;
            align_err      <= '0;
            code_err       <= '0;
            fcs_err        <= '0;
        end else if (link_up) begin   // frozen while the link is down
            rx_good_pkts   <= rx_good_pkts + COUNT_W'(samples.rx_good_packets);
            rx_total_pkts  <= rx_total_pkts + COUNT_W'(samples.rx_total_packets);
            rx_good_bytes  <= rx_good_bytes + COUNT_W'(samples.rx_good_bytes);
            rx_total_bytes <= rx_total_bytes + COUNT_W'(samples.rx_total_bytes);
            tx_good_pkts   <= tx_good_pkts + COUNT_W'(samples.tx_good_packets);
            tx_total_pkts  <= tx_total_pkts + COUNT_W'(samples.tx_total_packets);
            tx_good_bytes  <= tx_good_bytes + COUNT_W'(samples.tx_good_bytes);
            tx_total_bytes <= tx_total_bytes + COUNT_W'(samples.tx_total_bytes);
            // one event per cycle, whatever the field value
            if (samples.rx_aligned_err) begin
                align_err <= align_err + ERR_W'(1);
            end
            if (samples.rx_bad_code != '0) begin
                code_err <= code_err + ERR_W'(1);
            end
            if (samples.rx_bad_fcs != '0) begin
                fcs_err <= fcs_err + ERR_W'(1);
            end
        end
    end

    assign counters[SEL_RX_GOOD_PKTS]   = rx_good_pkts;
    assign counters[SEL_RX_TOTAL_PKTS]  = rx_total_pkts;
    assign counters[SEL_RX_GOOD_BYTES]  = rx_good_bytes;
    assign counters[SEL_RX_TOTAL_BYTES] = rx_total_bytes;
    assign counters[SEL_TX_GOOD_PKTS]   = tx_good_pkts;
    assign counters[SEL_TX_TOTAL_PKTS]  = tx_total_pkts;
    assign counters[SEL_TX_GOOD_BYTES]  = tx_good_bytes;
    assign counters[SEL_TX_TOTAL_BYTES] = tx_total_bytes;
    assign counters[SEL_ALIGN_ERR]      = COUNT_W'(align_err);   // zero-extended
    assign counters[SEL_CODE_ERR]       = COUNT_W'(code_err);
    assign counters[SEL_FCS_ERR]        = COUNT_W'(fcs_err);

endmodule

`default_nettype wire

// File: design/stat_readout.sv
/*
 * Counter read port. A valid/ready request selects a counter, its value
 * is held in a response register until the host takes it.
 */
`timescale 1ns/1ps
`default_nettype none

module stat_readout import cmac_stats_pkg::*; #(
    parameter int COUNT_W = $bits(count_t)
) (
    input  logic               cmac_drp,
    input  logic               usr_rx_reset_w,
    input  logic [COUNT_W-1:0] counters [NUM_STATS],
    input  logic               rd_req_valid,
    output logic               rd_req_ready,
    input  stat_sel_t          rd_sel,
    output logic               rd_resp_valid,
    input  logic               rd_resp_ready,
    output logic [COUNT_W-1:0] rd_resp_data
);

    logic req_fire;
    logic resp_fire;

    // free slot, or the held response leaves this cycle
    assign rd_req_ready = !rd_resp_valid || rd_resp_ready;
    assign req_fire     = rd_req_valid && rd_req_ready;
    assign resp_fire    = rd_resp_valid && rd_resp_ready;

    always_ff @(posedge cmac_drp) begin
        if (usr_rx_reset_w) begin
            rd_resp_valid <= 1'b0;
        end else if (req_fire) begin
            rd_resp_valid <= 1'b1;
        end else if (resp_fire) begin
            rd_resp_valid <= 1'b0;
        end
    end

    // data only loads on an accepted request, so it holds under back-pressure
    always_ff @(posedge cmac_drp) begin
        if (req_fire) begin
            rd_resp_data <= counters[rd_sel];
        end
    end

endmodule

`default_nettype wire

// File: design/cmac_link_ctrl.sv
/*
 * 100G MAC link bring-up and statistics controller, top level.
 * Connects the core status ports to the FSM, counters and read port.
 */
`timescale 1ns/1ps
`default_nettype none

module cmac_link_ctrl import cmac_stats_pkg::*; (
    input  logic           cmac_drp,
    input  logic           usr_rx_reset_w,
    input  logic           stat_rx_aligned,
    // per-cycle statistics from the MAC core
    input  logic           stat_rx_good_packets,
    input  rx_pkt_inc_t    stat_rx_total_packets,
    input  good_byte_inc_t stat_rx_good_bytes,
    input  rx_byte_inc_t   stat_rx_total_bytes,
    input  logic           stat_tx_good_packets,
    input  logic           stat_tx_total_packets,
    input  good_byte_inc_t stat_tx_good_bytes,
    input  tx_byte_inc_t   stat_tx_total_bytes,
    input  logic           stat_rx_aligned_err,
    input  err_field_t     stat_rx_bad_code,
    input  err_field_t     stat_rx_bad_fcs,
    // MAC control
    output logic           ctl_rx_enable,
    output logic           ctl_tx_enable,
    output logic           ctl_tx_send_lfi,
    output logic           ctl_tx_send_rfi,
    // host read port
    input  logic           rd_req_valid,
    output logic           rd_req_ready,
    input  stat_sel_t      rd_sel,
    output logic           rd_resp_valid,
    input  logic           rd_resp_ready,
    output count_t         rd_resp_data
);

    logic   link_up;
    count_t counters [NUM_STATS];

    stat_sample_if samples ();

    assign samples.rx_good_packets  = stat_rx_good_packets;
    assign samples.rx_total_packets = stat_rx_total_packets;
    assign samples.rx_good_bytes    = stat_rx_good_bytes;
    assign samples.rx_total_bytes   = stat_rx_total_bytes;
    assign samples.tx_good_packets  = stat_tx_good_packets;
    assign samples.tx_total_packets = stat_tx_total_packets;
    assign samples.tx_good_bytes    = stat_tx_good_bytes;
    assign samples.tx_total_bytes   = stat_tx_total_bytes;
    assign samples.rx_aligned_err   = stat_rx_aligned_err;
    assign samples.rx_bad_code      = stat_rx_bad_code;
    assign samples.rx_bad_fcs       = stat_rx_bad_fcs;

    link_bringup_fsm u_fsm (
        .cmac_drp        (cmac_drp),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .ctl_rx_enable   (ctl_rx_enable),
        .ctl_tx_enable   (ctl_tx_enable),
        .ctl_tx_send_lfi (ctl_tx_send_lfi),
        .ctl_tx_send_rfi (ctl_tx_send_rfi),
        .link_up         (link_up)
    );

    stat_counter_bank #(
        .COUNT_W (COUNT_W),
        .ERR_W   (ERR_W)
    ) u_counters (
        .cmac_drp       (cmac_drp),
        .usr_rx_reset_w (usr_rx_reset_w),
        .link_up        (link_up),
        .samples        (samples),
        .counters       (counters)
    );

    stat_readout #(
        .COUNT_W (COUNT_W)
    ) u_readout (
        .cmac_drp       (cmac_drp),
        .usr_rx_reset_w (usr_rx_reset_w),
        .counters       (counters),
        .rd_req_valid   (rd_req_valid),
        .rd_req_ready   (rd_req_ready),
        .rd_sel         (rd_sel),
        .rd_resp_valid  (rd_resp_valid),
        .rd_resp_ready  (rd_resp_ready),
        .rd_resp_data   (rd_resp_data)
    );

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
/*
 * Testbench clock and reset source. Reset is held for a number of
 * cycles and released on a falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 3
) (
    output logic cmac_drp,
    output logic usr_rx_reset_w
);

    initial begin
        cmac_drp = 1'b0;
        forever #(HALF_PERIOD) cmac_drp = ~cmac_drp;
    end

    initial begin
        usr_rx_reset_w = 1'b1;
        repeat (RESET_CYCLES) @(posedge cmac_drp);
        @(negedge cmac_drp);   // release away from the sampling edge
        usr_rx_reset_w = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_cmac_link_ctrl.sv
/*
 * Testbench for the MAC link controller. Drives random statistics traffic,
 * keeps a behavioral model of every counter and checks the read port.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cmac_link_ctrl import cmac_stats_pkg::*; ();

    localparam int TMO = 200;   // cycle limit of every wait

    logic           cmac_drp;
    logic           usr_rx_reset_w;
    logic           stat_rx_aligned;
    logic           stat_rx_good_packets;
    rx_pkt_inc_t    stat_rx_total_packets;
    good_byte_inc_t stat_rx_good_bytes;
    rx_byte_inc_t   stat_rx_total_bytes;
    logic           stat_tx_good_packets;
    logic           stat_tx_total_packets;
    good_byte_inc_t stat_tx_good_bytes;
    tx_byte_inc_t   stat_tx_total_bytes;
    logic           stat_rx_aligned_err;
    err_field_t     stat_rx_bad_code;
    err_field_t     stat_rx_bad_fcs;
    logic           ctl_rx_enable;
    logic           ctl_tx_enable;
    logic           ctl_tx_send_lfi;
    logic           ctl_tx_send_rfi;
    logic           rd_req_valid;
    logic           rd_req_ready;
    stat_sel_t      rd_sel;
    logic           rd_resp_valid;
    logic           rd_resp_ready;
    count_t         rd_resp_data;

    count_t      model [NUM_STATS];   // expected counter values
    count_t      expected_q [$];      // snapshots taken at request acceptance
    logic [31:0] rand_state = 32'hea32;
    logic        traffic_on;
    logic        err_on;
    logic        bp_on;
    logic        last_acc;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          e;
    int          t;
    int          reset_errs;
    int          bring_errs;

    clk_gen #(.HALF_PERIOD(2), .RESET_CYCLES(3)) u_clk (.cmac_drp, .usr_rx_reset_w);

    cmac_link_ctrl dut (.*);

    assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
        ctl_tx_enable |-> !ctl_tx_send_lfi && !ctl_tx_send_rfi)
    else begin
        errors++;
        $display("Mismatch at %0t: fault indication sent with transmitter on", $time);
    end

    assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
        rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp_data))
    else begin
        errors++;
        $display("Mismatch at %0t: held response changed before it was taken", $time);
    end

    assert property (@(posedge cmac_drp) disable iff (usr_rx_reset_w)
        rd_resp_valid && !rd_resp_ready |-> !rd_req_ready)
    else begin
        errors++;
        $display("Mismatch at %0t: request ready while a response is held", $time);
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Mismatch at %0t: %s", $time, what);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout waiting for %s at %0t", what, $time);
    endtask

    task automatic end_test(input string name, input int n);
        tests_run++;
        if (n != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "failed", n);
    endtask

    // random statistic inputs or zeros when traffic is off
    task automatic drive_traffic();
        logic [31:0] r;
        logic [31:0] q;
        r = xorshift(rand_state);
        q = xorshift(r);
        rand_state = q;
        if (!traffic_on) begin
            r = '0;
            q = '0;
        end
        stat_rx_good_packets  = r[0];
        stat_rx_total_packets = r[3:1];
        stat_rx_good_bytes    = r[17:4];
        stat_rx_total_bytes   = r[24:18];
        stat_tx_good_packets  = r[25];
        stat_tx_total_packets = r[26];
        stat_tx_good_bytes    = q[13:0];
        stat_tx_total_bytes   = q[19:14];
        stat_rx_aligned_err   = err_on & q[20];
        stat_rx_bad_code      = err_on ? q[23:21] : '0;
        stat_rx_bad_fcs       = err_on ? q[26:24] : '0;
    endtask

    // advance one clock from a falling edge and update the model
    task automatic cycle();
        logic   taken;
        logic   accepted;
        count_t exp;
        if (bp_on) begin
            rand_state    = xorshift(rand_state);
            rd_resp_ready = rand_state[9];
        end
        taken    = rd_resp_valid && rd_resp_ready;
        accepted = rd_req_valid && (!rd_resp_valid || rd_resp_ready);
        if (taken && expected_q.size() == 0) begin
            errors++;
            $display("read response without a request at %0t", $time);
        end else if (taken) begin
            exp = expected_q.pop_front();
            check(rd_resp_data === exp,
                  $sformatf("read data %h, expected %h", rd_resp_data, exp));
        end
        @(posedge cmac_drp);
        @(negedge cmac_drp);
        if (accepted) begin
            expected_q.push_back(model[rd_sel]);   // value before this edge
        end
        if (ctl_tx_enable) begin   // high after the edge means the link counted
            model[SEL_RX_GOOD_PKTS]   += COUNT_W'(stat_rx_good_packets);
            model[SEL_RX_TOTAL_PKTS]  += COUNT_W'(stat_rx_total_packets);
            model[SEL_RX_GOOD_BYTES]  += COUNT_W'(stat_rx_good_bytes);
            model[SEL_RX_TOTAL_BYTES] += COUNT_W'(stat_rx_total_bytes);
            model[SEL_TX_GOOD_PKTS]   += COUNT_W'(stat_tx_good_packets);
            model[SEL_TX_TOTAL_PKTS]  += COUNT_W'(stat_tx_total_packets);
            model[SEL_TX_GOOD_BYTES]  += COUNT_W'(stat_tx_good_bytes);
            model[SEL_TX_TOTAL_BYTES] += COUNT_W'(stat_tx_total_bytes);
            if (stat_rx_aligned_err) begin
                model[SEL_ALIGN_ERR] = COUNT_W'(ERR_W'(model[SEL_ALIGN_ERR] + 1'b1));
            end
            if (stat_rx_bad_code != '0) begin
                model[SEL_CODE_ERR] = COUNT_W'(ERR_W'(model[SEL_CODE_ERR] + 1'b1));
            end
            if (stat_rx_bad_fcs != '0) begin
                model[SEL_FCS_ERR] = COUNT_W'(ERR_W'(model[SEL_FCS_ERR] + 1'b1));
            end
        end
        last_acc = accepted;
        drive_traffic();
    endtask

    task automatic read_stat(input stat_sel_t sel);
        int n;
        rd_req_valid = 1'b1;
        rd_sel       = sel;
        n = 0;
        do begin
            cycle();
            n++;
        end while (!last_acc && n < TMO);
        rd_req_valid = 1'b0;
        if (!last_acc) begin
            report_timeout("request acceptance");
        end
        n = 0;
        while (expected_q.size() != 0 && n < TMO) begin
            cycle();
            n++;
        end
        if (expected_q.size() != 0) begin
            report_timeout("read response");
        end
    endtask

    // up waits for the transmitter and down for all controls to clear
    task automatic wait_link(input logic up);
        int n;
        n = 0;
        while ((up ? !ctl_tx_enable : ctl_rx_enable) && n < TMO) begin
            cycle();
            n++;
        end
        if (up ? !ctl_tx_enable : ctl_rx_enable) begin
            report_timeout(up ? "link up" : "link down");
        end
    endtask

    initial begin
        stat_rx_aligned = 1'b0;
        rd_req_valid    = 1'b0;
        rd_sel          = SEL_RX_GOOD_PKTS;
        rd_resp_ready   = 1'b1;
        traffic_on      = 1'b0;
        err_on          = 1'b0;
        bp_on           = 1'b0;
        last_acc        = 1'b0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        drive_traffic();
        t = 0;
        do begin
            @(posedge cmac_drp);
            t++;
        end while (usr_rx_reset_w && t < TMO);
        if (usr_rx_reset_w) begin
            report_timeout("reset release");
        end
        @(negedge cmac_drp);   // first edge after release is done

        e = errors;
        check(!ctl_rx_enable && !ctl_tx_enable && !ctl_tx_send_lfi && !ctl_tx_send_rfi,
              "control outputs not low after reset");
        check(!rd_resp_valid, "response valid after reset");
        reset_errs = errors - e;
        e = errors;
        cycle();
        check(!ctl_rx_enable, "receiver enabled before the third edge");
        cycle();
        check(ctl_rx_enable && ctl_tx_send_lfi && ctl_tx_send_rfi && !ctl_tx_enable,
              "bring-up outputs wrong after the third edge");
        bring_errs = errors - e;
        e = errors;
        for (int i = 0; i < NUM_STATS; i++) begin
            read_stat(stat_sel_t'(4'(i)));
        end
        end_test("reset", reset_errs + errors - e);

        e = errors;
        stat_rx_aligned = 1'b1;
        wait_link(1'b1);
        check(!ctl_tx_send_lfi && !ctl_tx_send_rfi, "fault indications sent with link up");
        end_test("bring-up", bring_errs + errors - e);

        e = errors;
        traffic_on = 1'b1;
        repeat (400) cycle();
        traffic_on = 1'b0;
        for (int i = 0; i < 8; i++) begin
            read_stat(stat_sel_t'(4'(i)));
        end
        end_test("accumulation", errors - e);

        e = errors;
        traffic_on = 1'b1;
        err_on     = 1'b1;
        repeat (300) cycle();
        traffic_on = 1'b0;
        for (int i = 8; i < NUM_STATS; i++) begin
            read_stat(stat_sel_t'(4'(i)));
        end
        end_test("error events", errors - e);

        e = errors;
        traffic_on      = 1'b1;   // traffic keeps running through the loss
        stat_rx_aligned = 1'b0;
        wait_link(1'b0);
        check(!ctl_tx_enable && !ctl_tx_send_lfi && !ctl_tx_send_rfi,
              "controls not cleared on link loss");
        repeat (50) cycle();
        traffic_on = 1'b0;
        for (int i = 0; i < NUM_STATS; i++) begin
            read_stat(stat_sel_t'(4'(i)));
        end
        check(ctl_rx_enable && ctl_tx_send_lfi && ctl_tx_send_rfi && !ctl_tx_enable,
              "bring-up not repeated after link loss");
        stat_rx_aligned = 1'b1;
        wait_link(1'b1);
        check(ctl_rx_enable, "receiver not enabled after link recovery");
        end_test("link loss", errors - e);

        e = errors;
        traffic_on = 1'b1;
        bp_on      = 1'b1;
        for (int i = 0; i < 3 * NUM_STATS; i++) begin
            read_stat(stat_sel_t'(4'(i % NUM_STATS)));
        end
        bp_on         = 1'b0;
        rd_resp_ready = 1'b1;
        traffic_on    = 1'b0;
        end_test("back-pressure", errors - e);

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cmac_link_ctrl.f
design/cmac_stats_pkg.sv
design/stat_sample_if.sv
design/link_bringup_fsm.sv
design/stat_counter_bank.sv
design/stat_readout.sv
design/cmac_link_ctrl.sv
verification/clk_gen.sv
verification/tb_cmac_link_ctrl.sv

// File: Makefile
# Verilator build and run of the MAC link controller testbench

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_cmac_link_ctrl
RTL_TOP  := cmac_link_ctrl
FILELIST := cmac_link_ctrl.f
LOG      := sim.log
PASS_MSG := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the log decides the result
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
